// File: bank_array/bank_array.sv
`timescale 1ns/1ps

module bank_array #(
  parameter int width    = 16,
  parameter int num_vbnk = 4,
  parameter int num_vrow = 16,
  localparam int num_pbnk = num_vbnk + 1,
  localparam int row_bits = $clog2(num_vrow)
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               rd_req,
  input  mem_map_pkg::pbank_t                rd_pbank,
  input  logic [row_bits-1:0]                rd_row,
  input  logic                               wr_req,
  input  mem_map_pkg::pbank_t                wr_pbank,
  input  logic [row_bits-1:0]                wr_row,
  input  logic [width-1:0]                   wr_data,
  output logic                               rd_vld_q,
  output mem_map_pkg::pbank_t                rd_pbank_q,
  output logic [num_pbnk-1:0][width-1:0]     bank_dout
);

  for (genvar b = 0; b < num_pbnk; b++) begin : g_bank
    logic [width-1:0] mem [num_vrow];
    logic [width-1:0] dout_q;
    logic             bank_rd;
    logic             bank_wr;

    // at most one of these is set per bank and cycle
    assign bank_rd = rd_req && (rd_pbank == b);
    assign bank_wr = wr_req && (wr_pbank == b);

    always_ff @(posedge clk) begin
      if (bank_wr) begin
        mem[wr_row] <= wr_data;
      end
      if (bank_rd) begin
        dout_q <= mem[rd_row];
      end
    end

    assign bank_dout[b] = dout_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_req;
    end
  end

  // bank index for the output select
  always_ff @(posedge clk) begin
    rd_pbank_q <= rd_pbank;
  end

endmodule

// File: bank_map/map_table.sv
`timescale 1ns/1ps

module map_table #(
  parameter int width    = 16,
  parameter int num_vbnk = 4,
  parameter int num_vrow = 16,
  localparam int vbank_bits = $clog2(num_vbnk),
  localparam int row_bits   = $clog2(num_vrow)
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rd_req_in,
  input  logic [vbank_bits-1:0]  rd_vbank_in,
  input  logic [row_bits-1:0]    rd_row_in,
  input  logic                   wr_req_in,
  input  logic [vbank_bits-1:0]  wr_vbank_in,
  input  logic [row_bits-1:0]    wr_row_in,
  input  logic [width-1:0]       wr_data_in,
  input  logic                   map_upd_en,
  input  logic [row_bits-1:0]    map_upd_row,
  input  mem_map_pkg::row_map_t  map_upd_word,
  output logic                   rd_req,
  output logic [vbank_bits-1:0]  rd_vbank,
  output logic [row_bits-1:0]    rd_row,
  output logic                   wr_req,
  output logic [vbank_bits-1:0]  wr_vbank,
  output logic [row_bits-1:0]    wr_row,
  output logic [width-1:0]       wr_data,
  output mem_map_pkg::row_map_t  rd_map,
  output mem_map_pkg::row_map_t  wr_map
);

  import mem_map_pkg::*;

  row_map_t map_mem [num_vrow];
  row_map_t rd_lookup;
  row_map_t wr_lookup;
  logic     rd_fwd;
  logic     wr_fwd;

  // an update landing on the looked-up row wins over the stored word
  assign rd_fwd = map_upd_en && (map_upd_row == rd_row_in);
  assign wr_fwd = map_upd_en && (map_upd_row == wr_row_in);

  assign rd_lookup = rd_fwd ? map_upd_word : map_mem[rd_row_in];
  assign wr_lookup = wr_fwd ? map_upd_word : map_mem[wr_row_in];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < num_vrow; r++) begin
        map_mem[r] <= identity_map();
      end
    end else if (map_upd_en) begin
      map_mem[map_upd_row] <= map_upd_word;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_req <= 1'b0;
      wr_req <= 1'b0;
    end else begin
      rd_req <= rd_req_in;
      wr_req <= wr_req_in;
    end
  end

  // request fields ride along with the lookup
  always_ff @(posedge clk) begin
    rd_vbank <= rd_vbank_in;
    rd_row   <= rd_row_in;
    wr_vbank <= wr_vbank_in;
    wr_row   <= wr_row_in;
    wr_data  <= wr_data_in;
    rd_map   <= rd_lookup;
    wr_map   <= wr_lookup;
  end

endmodule

// File: bank_map/write_steer.sv
`timescale 1ns/1ps

module write_steer #(
  parameter int num_vbnk = 4,
  parameter int num_vrow = 16,
  localparam int vbank_bits = $clog2(num_vbnk),
  localparam int row_bits   = $clog2(num_vrow)
) (
  input  logic                  rd_req,
  input  logic [vbank_bits-1:0] rd_vbank,
  input  logic                  wr_req,
  input  logic [vbank_bits-1:0] wr_vbank,
  input  logic [row_bits-1:0]   wr_row,
  input  mem_map_pkg::row_map_t rd_map,
  input  mem_map_pkg::row_map_t wr_map,
  output mem_map_pkg::pbank_t   rd_pbank,
  output mem_map_pkg::pbank_t   wr_pbank,
  output logic                  map_upd_en,
  output logic [row_bits-1:0]   map_upd_row,
  output mem_map_pkg::row_map_t map_upd_word
);

  import mem_map_pkg::*;

  pbank_t rd_mapped;
  pbank_t wr_mapped;
  pbank_t wr_free;
  logic   conflict;

  assign rd_mapped = rd_map[rd_vbank];
  assign wr_mapped = wr_map[wr_vbank];
  // the free entry sits right after the virtual bank entries
  assign wr_free   = wr_map[num_vbnk];

  // a single-port bank can't serve the read and the write together
  assign conflict = rd_req && wr_req && (rd_mapped == wr_mapped);

  assign rd_pbank = rd_mapped;
  assign wr_pbank = conflict ? wr_free : wr_mapped;

  assign map_upd_en  = conflict;
  assign map_upd_row = wr_row;

  // swap the written entry with the free entry
  always_comb begin
    map_upd_word = wr_map;
    map_upd_word[wr_vbank] = wr_free;
    map_upd_word[num_vbnk] = wr_mapped;
  end

endmodule

// File: common/mem_map_pkg.sv
package mem_map_pkg;

  // default memory geometry
  localparam int default_width    = 16;
  localparam int default_num_vbnk = 4;
  // one spare physical bank beyond the virtual ones
  localparam int default_num_pbnk = default_num_vbnk + 1;
  localparam int default_num_vrow = 16;
  // deliberately below the 64-word capacity
  localparam int default_num_addr = 60;

  localparam int pbank_bits = $clog2(default_num_pbnk);

  typedef logic [pbank_bits-1:0] pbank_t;

  // entries 0..num_vbnk-1 hold the physical bank of each virtual bank,
  // the top entry holds the row's free bank
  typedef pbank_t [default_num_pbnk-1:0] row_map_t;

  // virtual bank i in physical bank i, last bank free
  function automatic row_map_t identity_map();
    row_map_t m;
    for (int i = 0; i < default_num_pbnk; i++) begin
      m[i] = pbank_t'(i);
    end
    return m;
  endfunction

endpackage

// File: hdl/mem_1r1w_top.sv
`timescale 1ns/1ps

module mem_1r1w_top #(
  parameter int width    = mem_map_pkg::default_width,
  parameter int num_addr = mem_map_pkg::default_num_addr,
  parameter int num_vbnk = mem_map_pkg::default_num_vbnk,
  parameter int num_vrow = mem_map_pkg::default_num_vrow,
  localparam int addr_bits = $clog2(num_vbnk * num_vrow)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 read,
  input  logic [addr_bits-1:0] read_addr,
  input  logic                 write,
  input  logic [addr_bits-1:0] write_addr,
  input  logic [width-1:0]     write_data,
  output logic                 rd_vld,
  output logic [width-1:0]     rd_dout
);

  import mem_map_pkg::*;

  localparam int vbank_bits = $clog2(num_vbnk);
  localparam int row_bits   = $clog2(num_vrow);
  localparam int num_pbnk   = num_vbnk + 1;

  // s1, registered requests
  logic                  s1_rd_req;
  logic [vbank_bits-1:0] s1_rd_vbank;
  logic [row_bits-1:0]   s1_rd_row;
  logic                  s1_wr_req;
  logic [vbank_bits-1:0] s1_wr_vbank;
  logic [row_bits-1:0]   s1_wr_row;
  logic [width-1:0]      s1_wr_data;

  // s2, requests with their row maps
  logic                  s2_rd_req;
  logic [vbank_bits-1:0] s2_rd_vbank;
  logic [row_bits-1:0]   s2_rd_row;
  logic                  s2_wr_req;
  logic [vbank_bits-1:0] s2_wr_vbank;
  logic [row_bits-1:0]   s2_wr_row;
  logic [width-1:0]      s2_wr_data;
  row_map_t              s2_rd_map;
  row_map_t              s2_wr_map;

  pbank_t                rd_pbank;
  pbank_t                wr_pbank;
  logic                  map_upd_en;
  logic [row_bits-1:0]   map_upd_row;
  row_map_t              map_upd_word;

  // s3, bank outputs
  logic                           rd_vld_q;
  pbank_t                         rd_pbank_q;
  logic [num_pbnk-1:0][width-1:0] bank_dout;

  port_input #(
    .width(width), .num_addr(num_addr), .num_vbnk(num_vbnk), .num_vrow(num_vrow)
  ) u_port_input (
    .clk(clk), .rst(rst),
    .read(read), .read_addr(read_addr),
    .write(write), .write_addr(write_addr), .write_data(write_data),
    .rd_req(s1_rd_req), .rd_vbank(s1_rd_vbank), .rd_row(s1_rd_row),
    .wr_req(s1_wr_req), .wr_vbank(s1_wr_vbank), .wr_row(s1_wr_row),
    .wr_data(s1_wr_data)
  );

  map_table #(
    .width(width), .num_vbnk(num_vbnk), .num_vrow(num_vrow)
  ) u_map_table (
    .clk(clk), .rst(rst),
    .rd_req_in(s1_rd_req), .rd_vbank_in(s1_rd_vbank), .rd_row_in(s1_rd_row),
    .wr_req_in(s1_wr_req), .wr_vbank_in(s1_wr_vbank), .wr_row_in(s1_wr_row),
    .wr_data_in(s1_wr_data),
    .map_upd_en(map_upd_en), .map_upd_row(map_upd_row), .map_upd_word(map_upd_word),
    .rd_req(s2_rd_req), .rd_vbank(s2_rd_vbank), .rd_row(s2_rd_row),
    .wr_req(s2_wr_req), .wr_vbank(s2_wr_vbank), .wr_row(s2_wr_row),
    .wr_data(s2_wr_data), .rd_map(s2_rd_map), .wr_map(s2_wr_map)
  );

  write_steer #(
    .num_vbnk(num_vbnk), .num_vrow(num_vrow)
  ) u_write_steer (
    .rd_req(s2_rd_req), .rd_vbank(s2_rd_vbank),
    .wr_req(s2_wr_req), .wr_vbank(s2_wr_vbank), .wr_row(s2_wr_row),
    .rd_map(s2_rd_map), .wr_map(s2_wr_map),
    .rd_pbank(rd_pbank), .wr_pbank(wr_pbank),
    .map_upd_en(map_upd_en), .map_upd_row(map_upd_row), .map_upd_word(map_upd_word)
  );

  bank_array #(
    .width(width), .num_vbnk(num_vbnk), .num_vrow(num_vrow)
  ) u_bank_array (
    .clk(clk), .rst(rst),
    .rd_req(s2_rd_req), .rd_pbank(rd_pbank), .rd_row(s2_rd_row),
    .wr_req(s2_wr_req), .wr_pbank(wr_pbank), .wr_row(s2_wr_row), .wr_data(s2_wr_data),
    .rd_vld_q(rd_vld_q), .rd_pbank_q(rd_pbank_q), .bank_dout(bank_dout)
  );

  read_output #(
    .width(width), .num_vbnk(num_vbnk)
  ) u_read_output (
    .clk(clk), .rst(rst),
    .rd_vld_q(rd_vld_q), .rd_pbank_q(rd_pbank_q), .bank_dout(bank_dout),
    .rd_vld(rd_vld), .rd_dout(rd_dout)
  );

endmodule

// File: hdl/port_input.sv
`timescale 1ns/1ps

module port_input #(
  parameter int width    = 16,
  parameter int num_addr = 60,
  parameter int num_vbnk = 4,
  parameter int num_vrow = 16,
  localparam int addr_bits  = $clog2(num_vbnk * num_vrow),
  localparam int vbank_bits = $clog2(num_vbnk),
  localparam int row_bits   = $clog2(num_vrow)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read,
  input  logic [addr_bits-1:0]  read_addr,
  input  logic                  write,
  input  logic [addr_bits-1:0]  write_addr,
  input  logic [width-1:0]      write_data,
  output logic                  rd_req,
  output logic [vbank_bits-1:0] rd_vbank,
  output logic [row_bits-1:0]   rd_row,
  output logic                  wr_req,
  output logic [vbank_bits-1:0] wr_vbank,
  output logic [row_bits-1:0]   wr_row,
  output logic [width-1:0]      wr_data
);

  logic rd_in_range;
  logic wr_in_range;

  // addresses past the last word are dropped here
  assign rd_in_range = (read_addr < num_addr);
  assign wr_in_range = (write_addr < num_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_req <= 1'b0;
      wr_req <= 1'b0;
    end else begin
      rd_req <= read && rd_in_range;
      wr_req <= write && wr_in_range;
    end
  end

  // low bits pick the virtual bank, the rest is the row
  always_ff @(posedge clk) begin
    rd_vbank <= read_addr[vbank_bits-1:0];
    rd_row   <= read_addr[vbank_bits +: row_bits];
    wr_vbank <= write_addr[vbank_bits-1:0];
    wr_row   <= write_addr[vbank_bits +: row_bits];
    wr_data  <= write_data;
  end

endmodule

// File: hdl/read_output.sv
`timescale 1ns/1ps

module read_output #(
  parameter int width    = 16,
  parameter int num_vbnk = 4,
  localparam int num_pbnk = num_vbnk + 1
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           rd_vld_q,
  input  mem_map_pkg::pbank_t            rd_pbank_q,
  input  logic [num_pbnk-1:0][width-1:0] bank_dout,
  output logic                           rd_vld,
  output logic [width-1:0]               rd_dout
);

  logic [width-1:0] sel_dout;

  // only the bank that served the read holds fresh data
  assign sel_dout = bank_dout[rd_pbank_q];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= rd_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_vld_q) begin
      rd_dout <= sel_dout;
    end
  end

endmodule

// File: sources.f
+incdir+verif
common/mem_map_pkg.sv
hdl/port_input.sv
bank_map/map_table.sv
bank_map/write_steer.sv
bank_array/bank_array.sv
hdl/read_output.sv
hdl/mem_1r1w_top.sv
verif/tb_mem_1r1w.sv

// File: verif/tb_cases.svh
// columns: read, read_addr, write, write_addr, write_data, repeat count, test number
// each repeat steps both addresses and the write data by one
function automatic void load_cases();
  // idle, then reads of words nobody wrote yet
  add_case(0, 0, 0, 0, 16'h0000, 6, 1);
  add_case(1, 0, 0, 0, 16'h0000, 4, 1);
  add_case(0, 0, 0, 0, 16'h0000, 5, 1);
  // fill every in-range word, then read all of it back
  add_case(0, 0, 1, 0, 16'h1000, 60, 2);
  add_case(1, 0, 0, 0, 16'h0000, 60, 2);
  // read and write of one address together, then a read of the new data
  add_case(1, 5, 1, 5, 16'h5a50, 1, 3);
  add_case(1, 5, 0, 0, 16'h0000, 1, 3);
  add_case(1, 12, 1, 12, 16'h3c00, 4, 3);
  add_case(1, 12, 0, 0, 16'h0000, 4, 3);
  // back-to-back relocations in one row, twice over
  add_case(1, 8, 1, 8, 16'h4400, 4, 4);
  add_case(1, 8, 1, 8, 16'h4800, 4, 4);
  // same virtual banks in neighbouring rows
  add_case(1, 20, 1, 24, 16'h4c00, 4, 4);
  add_case(1, 24, 1, 20, 16'h4d00, 4, 4);
  add_case(1, 0, 0, 0, 16'h0000, 60, 4);
  // addresses past the last word
  add_case(0, 0, 1, 60, 16'hdead, 4, 5);
  add_case(1, 60, 1, 60, 16'hbeef, 4, 5);
  add_case(1, 56, 0, 0, 16'h0000, 4, 5);
  add_case(0, 0, 0, 0, 16'h0000, 4, 5);
endfunction

// File: verif/tb_mem_1r1w.sv
`timescale 1ns/1ps

module tb_mem_1r1w;

  import mem_map_pkg::*;

  localparam int width     = default_width;
  localparam int num_addr  = default_num_addr;
  localparam int addr_bits = $clog2(default_num_vbnk * default_num_vrow);
  localparam int rand_len  = 400;
  localparam int num_tests = 6;

  logic                 clk;
  logic                 rst;
  logic                 read;
  logic [addr_bits-1:0] read_addr;
  logic                 write;
  logic [addr_bits-1:0] write_addr;
  logic [width-1:0]     write_data;
  logic                 rd_vld;
  logic [width-1:0]     rd_dout;

  int c_rd[$];
  int c_raddr[$];
  int c_wr[$];
  int c_waddr[$];
  int c_wdata[$];
  int c_rep[$];
  int c_test[$];

  // reference model
  logic [width-1:0] model [num_addr];
  bit               written [num_addr];

  // outstanding reads, oldest first
  int               exp_due[$];
  int               exp_addr[$];
  logic [width-1:0] exp_data[$];
  bit               exp_known[$];
  int               exp_test[$];

  int          cyc;
  int          drv_test;
  int          next_report;
  int          test_errs [num_tests+2];
  int          checks;
  int          passed;
  int          failed;
  int          table_len;
  int          guard;
  bit          loaded;
  logic [31:0] lfsr;

  mem_1r1w_top #(
    .width(width), .num_addr(num_addr)
  ) UUT (
    .clk(clk), .rst(rst),
    .read(read), .read_addr(read_addr),
    .write(write), .write_addr(write_addr), .write_data(write_data),
    .rd_vld(rd_vld), .rd_dout(rd_dout)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic void add_case(int rd, int raddr, int wr, int waddr, int wdata,
                                   int rep, int test);
    c_rd.push_back(rd);
    c_raddr.push_back(raddr);
    c_wr.push_back(wr);
    c_waddr.push_back(waddr);
    c_wdata.push_back(wdata);
    c_rep.push_back(rep);
    c_test.push_back(test);
  endfunction

  `include "tb_cases.svh"

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic bit next_bit();
    bit b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic int rand_bits(int n);
    int v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(next_bit());
    end
    return v;
  endfunction

  // the read sees the model before this cycle's write lands
  task automatic apply(int rd, int raddr, int wr, int waddr, int wdata, int test);
    @(posedge clk);
    drv_test = test;
    read       <= (rd != 0);
    read_addr  <= addr_bits'(raddr);
    write      <= (wr != 0);
    write_addr <= addr_bits'(waddr);
    write_data <= width'(wdata);
    if (rd != 0 && raddr < num_addr) begin
      exp_due.push_back(cyc + 5);
      exp_addr.push_back(raddr);
      exp_data.push_back(model[raddr]);
      exp_known.push_back(written[raddr]);
      exp_test.push_back(test);
    end
    if (wr != 0 && waddr < num_addr) begin
      model[waddr] = width'(wdata);
      written[waddr] = 1'b1;
    end
  endtask

  function automatic void pop_expected();
    void'(exp_due.pop_front());
    void'(exp_addr.pop_front());
    void'(exp_data.pop_front());
    void'(exp_known.pop_front());
    void'(exp_test.pop_front());
  endfunction

  function automatic void check_read();
    if (rd_vld === 1'b1) begin
      if (exp_due.size() == 0) begin
        $display("unexpected rd_vld at %0t ns with no read outstanding", $time);
        test_errs[drv_test]++;
      end else begin
        if (exp_due[0] != cyc) begin
          $display("read of address %0d came back in cycle %0d instead of cycle %0d",
                   exp_addr[0], cyc, exp_due[0]);
          test_errs[exp_test[0]]++;
        end
        if (exp_known[0] && rd_dout !== exp_data[0]) begin
          $display("** Error at %0t ns: rd_dout (address %0d) expected %h, got %h",
                   $time, exp_addr[0], exp_data[0], rd_dout);
          test_errs[exp_test[0]]++;
        end
        checks++;
        pop_expected();
      end
    end else if (rd_vld !== 1'b0) begin
      $display("rd_vld is unknown at %0t ns", $time);
      test_errs[drv_test]++;
    end else if (exp_due.size() != 0 && exp_due[0] <= cyc) begin
      $display("no rd_vld for the read of address %0d due in cycle %0d",
               exp_addr[0], exp_due[0]);
      test_errs[exp_test[0]]++;
      pop_expected();
    end
  endfunction

  // a test is done once driving moved on and none of its reads are pending
  function automatic void report_tests();
    while (next_report < drv_test &&
           (exp_test.size() == 0 || exp_test[0] > next_report)) begin
      if (test_errs[next_report] == 0) begin
        $display("test %0d passed", next_report);
        passed++;
      end else begin
        $display("test %0d FAILED with %0d errors", next_report, test_errs[next_report]);
        failed++;
      end
      next_report++;
    end
  endfunction

  always @(negedge clk) begin
    if (!rst) begin
      check_read();
      report_tests();
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    read = 1'b0;
    read_addr = '0;
    write = 1'b0;
    write_addr = '0;
    write_data = '0;
    cyc = 0;
    drv_test = 1;
    next_report = 1;
    checks = 0;
    passed = 0;
    failed = 0;
    lfsr = 32'habe2ca44;
    for (int t = 0; t < num_tests + 2; t++) begin
      test_errs[t] = 0;
    end
    load_cases();
    table_len = 0;
    foreach (c_rep[i]) begin
      table_len += c_rep[i];
    end
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    foreach (c_rep[i]) begin
      for (int r = 0; r < c_rep[i]; r++) begin
        apply(c_rd[i], (c_raddr[i] + r) % (1 << addr_bits), c_wr[i],
              (c_waddr[i] + r) % (1 << addr_bits), c_wdata[i] + r, c_test[i]);
      end
    end
    for (int i = 0; i < rand_len; i++) begin
      apply(rand_bits(1), rand_bits(addr_bits), rand_bits(1), rand_bits(addr_bits),
            rand_bits(width), num_tests);
    end
    @(posedge clk);
    read  <= 1'b0;
    write <= 1'b0;

    // drain the last reads
    guard = 0;
    while (exp_due.size() != 0 && guard < 10) begin
      @(posedge clk);
      guard++;
    end
    // a stray rd_vld shows up within the pipeline depth
    repeat (4) @(posedge clk);
    drv_test = num_tests + 1;
    report_tests();

    $display("tests passed: %0d, tests failed: %0d, reads checked: %0d",
             passed, failed, checks);
    if (failed == 0 && passed == num_tests && test_errs[num_tests+1] == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((4 + table_len + rand_len + 20) * 10);
    $display("watchdog expired at %0t ns before the run finished", $time);
    $display("Test failed");
    $finish;
  end

endmodule
